//--- hw/panelInstPkg.sv
`default_nettype none

package panelInstPkg;

   localparam int CodeWidth = 4;
   localparam int ImmWidth  = 8;   // also the number of LEDs

   // 12-bit instruction layout: code in [11:8], immediate in [7:0]
   typedef enum logic [CodeWidth-1:0] {
      Nop = 4'h0,
      Rbs = 4'h1,   // read button status
      Ldi = 4'h2,   // load LEDs
      Ltg = 4'h3    // toggle LEDs
   } opcodeE;

   typedef struct packed {
      opcodeE              code;
      logic [ImmWidth-1:0] imm;
   } instT;

endpackage

`default_nettype wire

//--- hw/panelStatePkg.sv
`default_nettype none

package panelStatePkg;

   localparam int NumButtons     = 4;
   localparam int DebounceCycles = 4;   // cycles a level must hold

   localparam int DebounceWidth = $clog2(DebounceCycles);
   localparam logic [DebounceWidth-1:0] DebounceLast = DebounceWidth'(DebounceCycles - 1);

   // common device life cycle
   typedef enum logic [1:0] {
      Reset = 2'h0,
      Ready = 2'h1,
      Error = 2'h2    // sticky until reset
   } devStateE;

endpackage

`default_nettype wire

//--- hw/PushBtnInterface.sv
`default_nettype none
`timescale 1ns/10ps

module PushBtnInterface (
   input  logic clock,
   input  logic reset,
   input  logic button,
   output logic pressed
);

   logic                                     syncMeta;
   logic                                     syncLevel;
   logic                                     stable;
   logic [panelStatePkg::DebounceWidth-1:0]  count;

   // two-flop synchronizer, then a run-length filter on the synced level
   always_ff @(posedge clock) begin
      if (reset) begin
         syncMeta  <= 1'b0;
         syncLevel <= 1'b0;
         stable    <= 1'b0;
         count     <= '0;
         pressed   <= 1'b0;
      end else begin
         syncMeta  <= button;
         syncLevel <= syncMeta;
         pressed   <= 1'b0;   // single-cycle pulse

         if (syncLevel == stable) begin
            count <= '0;   // bounce back, start over
         end else if (count == panelStatePkg::DebounceLast) begin
            count   <= '0;
            stable  <= syncLevel;
            pressed <= syncLevel;   // rising edge only, release is silent
         end else begin
            count <= count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/PushBtn.sv
`default_nettype none
`timescale 1ns/10ps

module PushBtn (
   input  logic               clock,
   input  logic               reset,
   input  panelInstPkg::instT inst,
   input  logic               instEn,
   input  logic               button,
   output logic               buttonStatus,
   output logic               fault
);

   typedef struct packed {
      panelStatePkg::devStateE state;
      logic                    latch;    // press seen since last Rbs
      logic                    status;   // value shown on buttonStatus
   } btnRegT;

   btnRegT cur;
   btnRegT nxt;
   logic   pressed;

   PushBtnInterface pushBtnInterface_i (
      .clock   (clock),
      .reset   (reset),
      .button  (button),
      .pressed (pressed)
   );

   assign buttonStatus = cur.status;
   assign fault        = (cur.state == panelStatePkg::Error);

   always_ff @(posedge clock) begin
      cur <= nxt;
   end

   always_comb begin
      nxt = cur;
      if (reset) begin
         nxt.state  = panelStatePkg::Reset;
         nxt.latch  = 1'b0;
         nxt.status = 1'b0;
      end else begin
         case (cur.state)
            panelStatePkg::Reset: begin
               nxt.state  = panelStatePkg::Ready;   // strobes ignored here
               nxt.latch  = 1'b0;
               nxt.status = 1'b0;
            end

            panelStatePkg::Ready: begin
               nxt.latch = cur.latch | pressed;
               if (instEn) begin
                  case (inst.code)
                     panelInstPkg::Nop: begin
                        nxt.status = cur.status;
                     end

                     panelInstPkg::Rbs: begin
                        nxt.status = cur.latch;
                        nxt.latch  = pressed;   // keep a press landing this cycle
                     end

                     default: begin
                        nxt.state  = panelStatePkg::Error;
                        nxt.latch  = 1'b0;
                        nxt.status = 1'b0;
                     end
                  endcase
               end
            end

            default: begin
               // Error holds with outputs low until reset
               nxt.state  = panelStatePkg::Error;
               nxt.latch  = 1'b0;
               nxt.status = 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/LedBank.sv
`default_nettype none
`timescale 1ns/10ps

module LedBank (
   input  logic                              clock,
   input  logic                              reset,
   input  panelInstPkg::instT                inst,
   input  logic                              instEn,
   output logic [panelInstPkg::ImmWidth-1:0] leds,
   output logic                              fault
);

   typedef struct packed {
      panelStatePkg::devStateE           state;
      logic [panelInstPkg::ImmWidth-1:0] leds;
   } ledRegT;

   ledRegT cur;
   ledRegT nxt;

   assign leds  = cur.leds;
   assign fault = (cur.state == panelStatePkg::Error);

   always_ff @(posedge clock) begin
      cur <= nxt;
   end

   always_comb begin
      nxt = cur;
      if (reset) begin
         nxt.state = panelStatePkg::Reset;
         nxt.leds  = '0;
      end else begin
         case (cur.state)
            panelStatePkg::Reset: begin
               nxt.state = panelStatePkg::Ready;
               nxt.leds  = '0;
            end

            panelStatePkg::Ready: begin
               if (instEn) begin
                  case (inst.code)
                     panelInstPkg::Nop: begin
                        nxt.leds = cur.leds;
                     end

                     panelInstPkg::Ldi: begin
                        nxt.leds = inst.imm;
                     end

                     panelInstPkg::Ltg: begin
                        nxt.leds = cur.leds ^ inst.imm;   // flip where imm is set
                     end

                     default: begin
                        // Rbs lands here too, not a LED opcode
                        nxt.state = panelStatePkg::Error;
                        nxt.leds  = '0;
                     end
                  endcase
               end
            end

            default: begin
               nxt.state = panelStatePkg::Error;
               nxt.leds  = '0;   // dark while faulted
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/ButtonPanel.sv
`default_nettype none
`timescale 1ns/10ps

module ButtonPanel (
   input  logic                                 clock,
   input  logic                                 reset,
   input  panelInstPkg::instT                   inst,
   input  logic [panelStatePkg::NumButtons-1:0] btnInstEn,
   input  logic                                 ledInstEn,
   input  logic [panelStatePkg::NumButtons-1:0] buttons,
   output logic [panelStatePkg::NumButtons-1:0] buttonStatus,
   output logic [panelStatePkg::NumButtons-1:0] btnFault,
   output logic [panelInstPkg::ImmWidth-1:0]    leds,
   output logic                                 ledFault
);

   // one device per button, all sharing the instruction bus
   for (genvar i = 0; i < panelStatePkg::NumButtons; i++) begin : genBtn
      PushBtn pushBtn_i (
         .clock        (clock),
         .reset        (reset),
         .inst         (inst),
         .instEn       (btnInstEn[i]),     // per-device strobe
         .button       (buttons[i]),
         .buttonStatus (buttonStatus[i]),
         .fault        (btnFault[i])
      );
   end

   LedBank ledBank_i (
      .clock  (clock),
      .reset  (reset),
      .inst   (inst),
      .instEn (ledInstEn),
      .leds   (leds),
      .fault  (ledFault)
   );

endmodule

`default_nettype wire

//--- verif/ButtonPanelTb.sv
`default_nettype none
`timescale 1ns/10ps

module ButtonPanelTb;

   typedef struct packed {
      logic [panelStatePkg::NumButtons-1:0] btns;        // raw levels held for the row
      logic [panelStatePkg::NumButtons-1:0] waitPress;   // presses that must register
      logic [7:0]                           hold;
      logic                                 doReset;
      panelInstPkg::instT                   inst;
      logic [panelStatePkg::NumButtons-1:0] btnEn;
      logic                                 ledEn;
      logic [panelStatePkg::NumButtons-1:0] expStatus;
      logic [panelInstPkg::ImmWidth-1:0]    expLeds;
      logic [panelStatePkg::NumButtons-1:0] expBtnFault;
      logic                                 expLedFault;
   } rowT;

   logic                                 clock;
   logic                                 reset;
   panelInstPkg::instT                   inst;
   logic [panelStatePkg::NumButtons-1:0] btnInstEn;
   logic                                 ledInstEn;
   logic [panelStatePkg::NumButtons-1:0] buttons;
   logic [panelStatePkg::NumButtons-1:0] buttonStatus;
   logic [panelStatePkg::NumButtons-1:0] btnFault;
   logic [panelInstPkg::ImmWidth-1:0]    leds;
   logic                                 ledFault;

   logic [panelStatePkg::NumButtons-1:0] pressPulse;

   // reference model state
   logic [panelStatePkg::NumButtons-1:0] modelLatch;
   logic [panelStatePkg::NumButtons-1:0] modelStatus;
   logic [panelStatePkg::NumButtons-1:0] modelBtnFault;
   logic [panelInstPkg::ImmWidth-1:0]    modelLeds;
   logic                                 modelLedFault;

   rowT rows[$];

   ButtonPanel ButtonPanel_i (
      .clock        (clock),
      .reset        (reset),
      .inst         (inst),
      .btnInstEn    (btnInstEn),
      .ledInstEn    (ledInstEn),
      .buttons      (buttons),
      .buttonStatus (buttonStatus),
      .btnFault     (btnFault),
      .leds         (leds),
      .ledFault     (ledFault)
   );

   // debounced press pulses, only used to bound the wait for a press
   for (genvar g = 0; g < panelStatePkg::NumButtons; g++) begin : genTap
      assign pressPulse[g] = ButtonPanel_i.genBtn[g].pushBtn_i.pressed;
   end

   always #20 clock = ~clock;

   task automatic stopWithFailure();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic checkField(input int idx, input string name,
                             input logic [7:0] expected, input logic [7:0] actual);
      assert (actual === expected) else begin
         $display("MISMATCH %s row %0d expected %h actual %h", name, idx, expected, actual);
         stopWithFailure();
      end
   endtask

   task automatic applyReset();
      reset = 1'b1;
      repeat (5) @(negedge clock);
      reset = 1'b0;
      repeat (2) @(negedge clock);   // Reset state, then Ready
   endtask

   task automatic resetModel();
      modelLatch    = '0;
      modelStatus   = '0;
      modelBtnFault = '0;
      modelLeds     = '0;
      modelLedFault = 1'b0;
   endtask

   task automatic stepModel(input rowT r);
      logic [3:0] code;
      code = r.inst.code;
      if (r.doReset) begin
         resetModel();
      end
      for (int i = 0; i < panelStatePkg::NumButtons; i++) begin
         if (r.waitPress[i] && !modelBtnFault[i]) begin
            modelLatch[i] = 1'b1;
         end
         if (r.btnEn[i] && !modelBtnFault[i]) begin
            case (code)
               4'h0: begin
                  // nop keeps everything
               end
               4'h1: begin
                  modelStatus[i] = modelLatch[i];
                  modelLatch[i]  = 1'b0;
               end
               default: begin
                  modelBtnFault[i] = 1'b1;
                  modelStatus[i]   = 1'b0;
                  modelLatch[i]    = 1'b0;
               end
            endcase
         end
      end
      if (r.ledEn && !modelLedFault) begin
         case (code)
            4'h0: begin
               modelLeds = modelLeds;
            end
            4'h2: begin
               modelLeds = r.inst.imm;
            end
            4'h3: begin
               modelLeds = modelLeds ^ r.inst.imm;
            end
            default: begin
               modelLedFault = 1'b1;   // rbs and undefined codes trap
               modelLeds     = '0;
            end
         endcase
      end
   endtask

   function automatic void addRow(
      input logic [3:0] btns, input logic [3:0] waitPress, input logic [7:0] hold,
      input logic doReset, input logic [3:0] code, input logic [7:0] imm,
      input logic [3:0] btnEn, input logic ledEn, input logic [3:0] expStatus,
      input logic [7:0] expLeds, input logic [3:0] expBtnFault, input logic expLedFault);
      rowT r;
      r.btns        = btns;
      r.waitPress   = waitPress;
      r.hold        = hold;
      r.doReset     = doReset;
      r.inst        = panelInstPkg::instT'({code, imm});
      r.btnEn       = btnEn;
      r.ledEn       = ledEn;
      r.expStatus   = expStatus;
      r.expLeds     = expLeds;
      r.expBtnFault = expBtnFault;
      r.expLedFault = expLedFault;
      rows.push_back(r);
   endfunction

   // btns wait hold rst code imm btnEn ledEn / status leds btnFault ledFault
   function automatic void buildTable();
      addRow(4'b0000, 4'b0000, 8'd2, 1'b0, 4'h0, 8'h00, 4'b1111, 1'b1,
             4'b0000, 8'h00, 4'b0000, 1'b0);   // nop everywhere
      addRow(4'b0100, 4'b0100, 8'd2, 1'b0, 4'h0, 8'h00, 4'b0000, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);   // press button 2, no read yet
      addRow(4'b0000, 4'b0000, 8'd8, 1'b0, 4'h1, 8'h00, 4'b0100, 1'b0,
             4'b0100, 8'h00, 4'b0000, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h1, 8'h00, 4'b0100, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);   // latch was cleared
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h1, 8'h00, 4'b1111, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);
      addRow(4'b0010, 4'b0000, 8'd1, 1'b0, 4'h0, 8'h00, 4'b0000, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);   // short bounce
      addRow(4'b0000, 4'b0000, 8'd8, 1'b0, 4'h1, 8'h00, 4'b0010, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);
      addRow(4'b0010, 4'b0010, 8'd4, 1'b0, 4'h0, 8'h00, 4'b0000, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);   // long press
      addRow(4'b0000, 4'b0000, 8'd8, 1'b0, 4'h1, 8'h00, 4'b0010, 1'b0,
             4'b0010, 8'h00, 4'b0000, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h2, 8'hA5, 4'b0000, 1'b1,
             4'b0010, 8'hA5, 4'b0000, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h3, 8'h0F, 4'b0000, 1'b1,
             4'b0010, 8'hAA, 4'b0000, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h3, 8'h00, 4'b0000, 1'b1,
             4'b0010, 8'hAA, 4'b0000, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h0, 8'hFF, 4'b1111, 1'b1,
             4'b0010, 8'hAA, 4'b0000, 1'b0);   // nop leaves live state alone
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h7, 8'h00, 4'b0010, 1'b0,
             4'b0000, 8'hAA, 4'b0010, 1'b0);   // undefined code traps button 1
      addRow(4'b0010, 4'b0010, 8'd2, 1'b0, 4'h0, 8'h00, 4'b0000, 1'b0,
             4'b0000, 8'hAA, 4'b0010, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd8, 1'b0, 4'h1, 8'h00, 4'b0010, 1'b0,
             4'b0000, 8'hAA, 4'b0010, 1'b0);
      addRow(4'b1000, 4'b1000, 8'd2, 1'b0, 4'h0, 8'h00, 4'b0000, 1'b0,
             4'b0000, 8'hAA, 4'b0010, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd8, 1'b0, 4'h1, 8'h00, 4'b1000, 1'b0,
             4'b1000, 8'hAA, 4'b0010, 1'b0);   // button 3 still fine
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h1, 8'h00, 4'b0000, 1'b1,
             4'b1000, 8'h00, 4'b0010, 1'b1);   // rbs is not a LED opcode
      addRow(4'b0000, 4'b0000, 8'd1, 1'b1, 4'h0, 8'h00, 4'b0000, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h1, 8'h3C, 4'b1111, 1'b0,
             4'b0000, 8'h00, 4'b0000, 1'b0);
      addRow(4'b0000, 4'b0000, 8'd1, 1'b0, 4'h2, 8'h3C, 4'b0000, 1'b1,
             4'b0000, 8'h3C, 4'b0000, 1'b0);
   endfunction

   task automatic applyRow(input rowT r, input int idx);
      logic [panelStatePkg::NumButtons-1:0] seen;
      int                                   waited;
      seen   = '0;
      waited = 0;
      buttons = r.btns;
      if (r.doReset) begin
         applyReset();
      end
      while ((seen & r.waitPress) != r.waitPress) begin
         if (waited == 20) begin
            $display("row %0d: press on buttons %b never registered within 20 cycles",
                     idx, r.waitPress & ~seen);
            stopWithFailure();
         end
         @(negedge clock);
         seen   = seen | pressPulse;
         waited = waited + 1;
      end
      repeat (r.hold) @(negedge clock);

      inst      = r.inst;   // one-cycle strobe
      btnInstEn = r.btnEn;
      ledInstEn = r.ledEn;
      @(negedge clock);
      inst      = '0;
      btnInstEn = '0;
      ledInstEn = 1'b0;

      stepModel(r);
      assert (modelStatus === r.expStatus && modelLeds === r.expLeds &&
              modelBtnFault === r.expBtnFault && modelLedFault === r.expLedFault) else begin
         $display("row %0d: table expectation disagrees with the reference model", idx);
         stopWithFailure();
      end
      checkField(idx, "buttonStatus", 8'(r.expStatus), 8'(buttonStatus));
      checkField(idx, "leds", r.expLeds, leds);
      checkField(idx, "btnFault", 8'(r.expBtnFault), 8'(btnFault));
      checkField(idx, "ledFault", 8'(r.expLedFault), 8'(ledFault));
   endtask

   initial begin
      clock     = 1'b0;
      reset     = 1'b1;
      inst      = '0;
      btnInstEn = '0;
      ledInstEn = 1'b0;
      buttons   = '0;
      buildTable();
      resetModel();
      applyReset();
      for (int i = 0; i < rows.size(); i++) begin
         applyRow(rows[i], i);
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
hw/panelInstPkg.sv
hw/panelStatePkg.sv
hw/PushBtnInterface.sv
hw/PushBtn.sv
hw/LedBank.sv
hw/ButtonPanel.sv
verif/ButtonPanelTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ButtonPanelTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
